// File: dual_issue_top.f
+incdir+logic
logic/issue_pkg.sv
logic/decoded_if.sv
logic/inst_decoder.sv
logic/pair_issue_ctrl.sv
logic/issue_pipe_reg.sv
logic/dual_issue_top.sv
verification/issue_checker.sv
verification/dual_issue_tb.sv

// File: Bender.yml
package:
  name: dual_issue

export_include_dirs:
  - logic

sources:
  - logic/issue_pkg.sv
  - logic/decoded_if.sv
  - logic/inst_decoder.sv
  - logic/pair_issue_ctrl.sv
  - logic/issue_pipe_reg.sv
  - logic/dual_issue_top.sv
  - target: simulation
    files:
      - verification/issue_checker.sv
      - verification/dual_issue_tb.sv

// File: verification/dual_issue_tb.sv
`include "issue_settings.svh"

module dual_issue_tb;

    localparam int RAND_CYCLES = 300;
    localparam int TEST_CYCLES = 16 + 8 + 5 * (RAND_CYCLES + 4);
    localparam int WATCHDOG_T = (TEST_CYCLES + 200) * 100;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    cls_refetch;
    issue_pkg::fetch_entry_t entry_1;
    issue_pkg::fetch_entry_t entry_2;
    logic                    entry_1_ok;
    logic                    entry_2_ok;
    logic                    pop_1;
    logic                    pop_2;
    logic out_valid_1, out_w_reg_ena_1, out_in_ds_1, out_refetch_1;
    logic out_adel_1, out_tlb_refill_1, out_tlb_invalid_1;
    logic out_valid_2, out_w_reg_ena_2, out_in_ds_2, out_refetch_2;
    logic out_adel_2, out_tlb_refill_2, out_tlb_invalid_2;
    logic [`ISSUE_XLEN-1:0]  out_pc_1, out_inst_1, out_pc_2, out_inst_2;
    logic [`ISSUE_REG_W-1:0] out_w_reg_dst_1, out_w_reg_dst_2;

    logic [15:0] lfsr = 16'd21461;
    logic [31:0] pc_next = 32'h0000_1000;
    int tb_errs = 0;
    int err_base = 0;
    int n_pass = 0;
    int n_fail = 0;
    int n_pair, n_solo, n_ds1, n_ds2, n_ref, n_fault, n_hold;

    dual_issue_top u_dut (.*);

    issue_checker u_chk (
        .clk, .rst, .stall, .cls_refetch, .ok_1(entry_1_ok), .ok_2(entry_2_ok),
        .entry_1, .entry_2, .pop_1, .pop_2,
        .out_1({out_valid_1, out_pc_1, out_inst_1, out_w_reg_ena_1, out_w_reg_dst_1,
                out_in_ds_1, out_refetch_1, out_adel_1, out_tlb_refill_1, out_tlb_invalid_1}),
        .out_2({out_valid_2, out_pc_2, out_inst_2, out_w_reg_ena_2, out_w_reg_dst_2,
                out_in_ds_2, out_refetch_2, out_adel_2, out_tlb_refill_2, out_tlb_invalid_2})
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] template_word(input int t, input logic [4:0] rs,
                                                  input logic [4:0] rt, input logic [4:0] rd);
        case (t)
            0: return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            1: return {6'h09, rs, rt, 16'h0010};
            2: return {6'h0d, rs, rt, 16'h00ff};
            3: return {6'h00, 5'd0, rt, rd, 5'd2, 6'h00};
            4: return {6'h00, rs, rt, rd, 5'd0, 6'h20};
            5: return {6'h1c, rs, rt, rd, 5'd0, 6'h02};
            6: return {6'h00, 10'd0, rd, 5'd0, 6'h10};
            7: return {6'h23, rs, rt, 16'h0004};
            8: return {6'h2b, rs, rt, 16'h0008};
            9: return {6'h04, rs, rt, 16'h0003};
            10: return {6'h02, 26'h0000400};
            11: return {6'h03, 26'h0000400};
            12: return {6'h00, rs, 15'd0, 6'h08};
            13: return {6'h10, 5'h00, rt, rd, 11'd0};
            14: return {6'h10, 5'h10, 15'd0, 6'h02};
            15: return {6'h10, 5'h10, 15'd0, 6'h01};
            16: return {6'h10, 5'h10, 15'd0, 6'h08};
            default: return {6'h3f, rs, rt, 16'h0000};
        endcase
    endfunction

    // registers 0..7 only, so RAW and $0 cases come up often
    function automatic issue_pkg::fetch_entry_t make_entry(input int mode);
        issue_pkg::fetch_entry_t e;
        logic [4:0]              rs;
        logic [4:0]              rt;
        logic [4:0]              rd;
        logic [2:0]              r;
        int                      t;
        rs = 5'(rand_bits(3));
        rt = 5'(rand_bits(3));
        rd = 5'(rand_bits(3));
        r = 3'(rand_bits(3));
        case (mode)
            2: t = int'(r[1:0]);
            3: t = r[2] ? 9 + int'(r[1:0]) : int'(r[1:0]);
            4: t = r[2] ? (r[1:0] == 2'd3 ? 16 : 14 + int'(r[0])) : int'(r[1:0]);
            default: t = int'(rand_bits(5) % 18);
        endcase
        e = '0;
        e.inst = template_word(t, rs, rt, rd);
        e.pc = pc_next;
        pc_next = pc_next + 32'd4;
        if (mode == 5) begin
            if (rand_bits(3) == 0) begin
                e.pc[1:0] = 2'(rand_bits(2));
            end
            e.i_refill = rand_bits(3) == 0;
            e.i_invalid = rand_bits(3) == 0;
        end
        return e;
    endfunction

    task expect_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail t=%0t %s: expected %b, got %b", $time, name, exp, act);
            tb_errs++;
        end
    endtask

    task idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
            entry_1_ok = 1'b0;
            entry_2_ok = 1'b0;
            stall = 1'b0;
            cls_refetch = 1'b0;
        end
    endtask

    // fetch queue model, pops sampled mid-cycle
    task run_stream(input int mode, input int cycles);
        issue_pkg::fetch_entry_t q[$];
        logic                    p1;
        logic                    p2;
        q.delete();
        n_pair = 0;
        n_solo = 0;
        n_ds1 = 0;
        n_ds2 = 0;
        n_ref = 0;
        n_fault = 0;
        n_hold = 0;
        repeat (cycles) begin
            while (q.size() < 2) begin
                q.push_back(make_entry(mode));
            end
            @(posedge clk);
            #10;
            entry_1 = q[0];
            entry_2 = q[1];
            entry_1_ok = 1'b1;
            entry_2_ok = rand_bits(3) != 0;
            stall = (mode == 6) ? rand_bits(1) != 0 : (mode >= 3 && rand_bits(3) == 0);
            cls_refetch = mode >= 4 && rand_bits(3) == 0;
            @(negedge clk);
            p1 = pop_1;
            p2 = pop_2;
            if (p1) begin
                void'(q.pop_front());
            end
            if (p2) begin
                void'(q.pop_front());
            end
            n_pair += int'(p2);
            n_solo += int'(p1 && !p2);
            n_ds1 += int'(out_valid_1 && out_in_ds_1);
            n_ds2 += int'(out_valid_2 && out_in_ds_2);
            n_ref += int'(out_valid_1 && out_refetch_1);
            n_fault += int'(out_valid_1 && (out_adel_1 || out_tlb_refill_1 || out_tlb_invalid_1));
            n_hold += int'(stall && out_valid_1);
        end
        idle(4);
    endtask

    task finish_test(input string name, input logic covered, input string missing);
        int errs;
        if (!covered) begin
            $display("test %s: %s", name, missing);
            tb_errs++;
        end
        errs = tb_errs + u_chk.err_count - err_base;
        if (errs == 0) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        err_base = tb_errs + u_chk.err_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_T);
        $display("timeout: run still going after %0d time units", WATCHDOG_T);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        cls_refetch = 1'b0;
        entry_1 = '0;
        entry_2 = '0;
        entry_1_ok = 1'b0;
        entry_2_ok = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // no pops with one ok low, then none under stall
        entry_1 = make_entry(2);
        entry_2 = make_entry(2);
        entry_1_ok = 1'b1;
        @(negedge clk);
        expect_bit("pop_1", 1'b0, pop_1);
        expect_bit("out_valid_1", 1'b0, out_valid_1);
        expect_bit("out_valid_2", 1'b0, out_valid_2);
        @(posedge clk);
        #10;
        entry_2_ok = 1'b1;
        stall = 1'b1;
        @(negedge clk);
        expect_bit("pop_1", 1'b0, pop_1);
        expect_bit("pop_2", 1'b0, pop_2);
        idle(4);
        finish_test("reset_and_idle", 1'b1, "");

        run_stream(2, RAND_CYCLES);
        finish_test("alu_pairs", n_pair > 0 && n_solo > 0, "paired and lone issues not both seen");
        run_stream(3, RAND_CYCLES);
        finish_test("delay_slot", n_ds1 > 0 && n_ds2 > 0, "no delay slot issue was seen");
        run_stream(4, RAND_CYCLES);
        finish_test("tlb_refetch", n_ref > 0, "refetch flag never reached the output");
        run_stream(5, RAND_CYCLES);
        finish_test("fetch_faults", n_fault > 0, "no slot 1 fault reached the output");
        run_stream(6, RAND_CYCLES);
        finish_test("stall_hold", n_hold > 0, "no valid output was held under stall");

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && tb_errs + u_chk.err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verification/issue_checker.sv
`include "issue_settings.svh"

module issue_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    stall,
    input logic                    cls_refetch,
    input logic                    ok_1,
    input logic                    ok_2,
    input issue_pkg::fetch_entry_t entry_1,
    input issue_pkg::fetch_entry_t entry_2,
    input logic                    pop_1,
    input logic                    pop_2,
    input logic [75:0]             out_1,
    input logic [75:0]             out_2
);

    typedef struct packed {
        logic       w_ena;
        logic [4:0] dst;
        logic       jmp;
        // slot 2 of this class never pairs
        logic       solo;
        logic       tlb;
        logic       tlb_rw;
    } ref_dec_t;

    typedef struct packed {
        logic                    valid;
        logic [`ISSUE_XLEN-1:0]  pc;
        logic [`ISSUE_XLEN-1:0]  inst;
        logic                    w_ena;
        logic [`ISSUE_REG_W-1:0] w_dst;
        logic                    in_ds;
        logic                    refetch;
        logic                    adel;
        logic                    refill;
        logic                    invalid;
    } slot_t;

    int       err_count = 0;
    logic     primed = 1'b0;
    ref_dec_t d1;
    ref_dec_t d2;
    logic     [1:0] pops;
    logic     m_in_ds;
    logic     m_refetch;
    slot_t    exp_1;
    slot_t    exp_2;

    function automatic ref_dec_t ref_decode(input logic [31:0] w);
        ref_dec_t   d;
        logic [5:0] fn;
        logic       has_dst;
        logic [4:0] dst;
        fn = w[5:0];
        d = '0;
        has_dst = 1'b0;
        dst = w[15:11];
        case (w[31:26])
            6'h00: begin
                case (fn)
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h21, 6'h23,
                    6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: has_dst = 1'b1;
                    // overflow checks and mfhi/mflo
                    6'h20, 6'h22, 6'h10, 6'h12: begin
                        has_dst = 1'b1;
                        d.solo = 1'b1;
                    end
                    6'h08, 6'h09: begin
                        d.jmp = 1'b1;
                        has_dst = fn[0];
                    end
                    default: d.solo = 1'b1;
                endcase
            end
            6'h01: begin
                d.jmp = w[20:17] == 4'd0;
                d.solo = w[20:17] != 4'd0;
            end
            6'h02, 6'h04, 6'h05, 6'h06, 6'h07: d.jmp = 1'b1;
            6'h03: begin
                d.jmp = 1'b1;
                has_dst = 1'b1;
                dst = `ISSUE_LINK_REG;
            end
            6'h08: begin
                has_dst = 1'b1;
                dst = w[20:16];
                d.solo = 1'b1;
            end
            6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                has_dst = 1'b1;
                dst = w[20:16];
            end
            6'h10: begin
                d.solo = 1'b1;
                has_dst = w[25:21] == 5'h00;
                dst = w[20:16];
                if (w[25:21] == 5'h10) begin
                    d.tlb = fn == 6'h01 || fn == 6'h02 || fn == 6'h08;
                    d.tlb_rw = fn == 6'h01 || fn == 6'h02;
                end
            end
            6'h1c: begin
                d.solo = 1'b1;
                has_dst = fn == 6'h02;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                d.solo = 1'b1;
                has_dst = 1'b1;
                dst = w[20:16];
            end
            // stores and reserved words
            default: d.solo = 1'b1;
        endcase
        d.w_ena = has_dst && dst != 5'd0;
        d.dst = has_dst ? dst : 5'd0;
        return d;
    endfunction

    function automatic logic [1:0] ref_pops(input issue_pkg::fetch_entry_t e2,
                                            input ref_dec_t a, input ref_dec_t b,
                                            input logic in_ds);
        logic p1;
        logic raw;
        logic block;
        p1 = !stall && ok_1 && ok_2;
        raw = a.w_ena && (a.dst == e2.inst[25:21] || a.dst == e2.inst[20:16]);
        block = in_ds || raw || b.jmp || b.solo || a.tlb ||
                e2.pc[1:0] != 2'b00 || e2.i_refill || e2.i_invalid;
        return {p1, p1 && !block};
    endfunction

    function automatic slot_t build_slot(input logic valid, input issue_pkg::fetch_entry_t e,
                                         input ref_dec_t d, input logic in_ds,
                                         input logic refetch);
        slot_t s;
        s.valid = valid;
        s.pc = e.pc;
        s.inst = e.inst;
        s.w_ena = d.w_ena;
        s.w_dst = d.dst;
        s.in_ds = in_ds;
        s.refetch = refetch;
        s.adel = e.pc[1:0] != 2'b00;
        s.refill = e.i_refill;
        s.invalid = e.i_invalid;
        return s;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail t=%0t %s: expected %h, got %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_slot(input int n, input slot_t e, input slot_t a);
        check_field($sformatf("out_valid_%0d", n), 32'(e.valid), 32'(a.valid));
        if (e.valid) begin
            check_field($sformatf("out_pc_%0d", n), e.pc, a.pc);
            check_field($sformatf("out_inst_%0d", n), e.inst, a.inst);
            check_field($sformatf("out_w_reg_ena_%0d", n), 32'(e.w_ena), 32'(a.w_ena));
            check_field($sformatf("out_w_reg_dst_%0d", n), 32'(e.w_dst), 32'(a.w_dst));
            check_field($sformatf("out_in_ds_%0d", n), 32'(e.in_ds), 32'(a.in_ds));
            check_field($sformatf("out_refetch_%0d", n), 32'(e.refetch), 32'(a.refetch));
            check_field($sformatf("out_adel_%0d", n), 32'(e.adel), 32'(a.adel));
            check_field($sformatf("out_tlb_refill_%0d", n), 32'(e.refill), 32'(a.refill));
            check_field($sformatf("out_tlb_invalid_%0d", n), 32'(e.invalid), 32'(a.invalid));
        end
    endtask

    // inputs are settled mid-cycle, outputs show the last edge
    always @(negedge clk) begin
        if (primed) begin
            compare_slot(1, exp_1, slot_t'(out_1));
            compare_slot(2, exp_2, slot_t'(out_2));
        end
        d1 = ref_decode(entry_1.inst);
        d2 = ref_decode(entry_2.inst);
        pops = ref_pops(entry_2, d1, d2, m_in_ds);
        check_field("pop_1", 32'(pops[1]), 32'(pop_1));
        check_field("pop_2", 32'(pops[0]), 32'(pop_2));
        if (!stall) begin
            exp_1 = build_slot(pops[1], entry_1, d1, m_in_ds, m_refetch);
            exp_2 = build_slot(pops[0], entry_2, d2, d1.jmp && pops[0], m_refetch);
        end
        if (rst) begin
            exp_1.valid = 1'b0;
            exp_2.valid = 1'b0;
            m_in_ds = 1'b0;
            m_refetch = 1'b0;
        end else begin
            if (pops[1]) begin
                m_in_ds = d1.jmp && !pops[0];
            end
            if (m_refetch) begin
                m_refetch = !cls_refetch;
            end else begin
                m_refetch = (pops[1] && d1.tlb_rw) || (pops[0] && d2.tlb_rw);
            end
        end
        primed = 1'b1;
    end

endmodule

// File: logic/dual_issue_top.sv
`include "issue_settings.svh"

module dual_issue_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      cls_refetch,
    input  logic [`ISSUE_ENTRY_W-1:0] entry_1,
    input  logic                      entry_1_ok,
    input  logic [`ISSUE_ENTRY_W-1:0] entry_2,
    input  logic                      entry_2_ok,
    output logic                      pop_1,
    output logic                      pop_2,
    output logic                      out_valid_1,
    output logic [`ISSUE_XLEN-1:0]    out_pc_1,
    output logic [`ISSUE_XLEN-1:0]    out_inst_1,
    output logic                      out_w_reg_ena_1,
    output logic [`ISSUE_REG_W-1:0]   out_w_reg_dst_1,
    output logic                      out_in_ds_1,
    output logic                      out_refetch_1,
    output logic                      out_adel_1,
    output logic                      out_tlb_refill_1,
    output logic                      out_tlb_invalid_1,
    output logic                      out_valid_2,
    output logic [`ISSUE_XLEN-1:0]    out_pc_2,
    output logic [`ISSUE_XLEN-1:0]    out_inst_2,
    output logic                      out_w_reg_ena_2,
    output logic [`ISSUE_REG_W-1:0]   out_w_reg_dst_2,
    output logic                      out_in_ds_2,
    output logic                      out_refetch_2,
    output logic                      out_adel_2,
    output logic                      out_tlb_refill_2,
    output logic                      out_tlb_invalid_2
);

    issue_pkg::fetch_entry_t ent_1;
    issue_pkg::fetch_entry_t ent_2;
    logic                    in_ds_1;
    logic                    in_ds_2;
    logic                    refetch;

    assign ent_1 = entry_1;
    assign ent_2 = entry_2;

    decoded_if dec_1 ();
    decoded_if dec_2 ();

    inst_decoder u_dec_1 (.inst(ent_1.inst), .dec(dec_1));
    inst_decoder u_dec_2 (.inst(ent_2.inst), .dec(dec_2));

    pair_issue_ctrl u_ctrl (
        .clk(clk), .rst(rst), .stall(stall), .cls_refetch(cls_refetch),
        .ok_1(entry_1_ok), .ok_2(entry_2_ok), .d1(dec_1), .d2(dec_2),
        .pc_1(ent_1.pc), .pc_2(ent_2.pc),
        .i_refill_2(ent_2.i_refill), .i_invalid_2(ent_2.i_invalid),
        .pop_1(pop_1), .pop_2(pop_2),
        .in_ds_1(in_ds_1), .in_ds_2(in_ds_2), .refetch(refetch)
    );

    issue_pipe_reg u_pipe (
        .clk(clk), .rst(rst), .stall(stall), .pop_1(pop_1), .pop_2(pop_2),
        .entry_1(ent_1), .entry_2(ent_2), .d1(dec_1), .d2(dec_2),
        .in_ds_1(in_ds_1), .in_ds_2(in_ds_2), .refetch(refetch),
        .out_valid_1(out_valid_1), .out_pc_1(out_pc_1), .out_inst_1(out_inst_1),
        .out_w_reg_ena_1(out_w_reg_ena_1), .out_w_reg_dst_1(out_w_reg_dst_1),
        .out_in_ds_1(out_in_ds_1), .out_refetch_1(out_refetch_1),
        .out_adel_1(out_adel_1), .out_tlb_refill_1(out_tlb_refill_1),
        .out_tlb_invalid_1(out_tlb_invalid_1),
        .out_valid_2(out_valid_2), .out_pc_2(out_pc_2), .out_inst_2(out_inst_2),
        .out_w_reg_ena_2(out_w_reg_ena_2), .out_w_reg_dst_2(out_w_reg_dst_2),
        .out_in_ds_2(out_in_ds_2), .out_refetch_2(out_refetch_2),
        .out_adel_2(out_adel_2), .out_tlb_refill_2(out_tlb_refill_2),
        .out_tlb_invalid_2(out_tlb_invalid_2)
    );

endmodule

// File: logic/issue_pipe_reg.sv
`include "issue_settings.svh"

module issue_pipe_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     pop_1,
    input  logic                     pop_2,
    input  issue_pkg::fetch_entry_t  entry_1,
    input  issue_pkg::fetch_entry_t  entry_2,
    decoded_if.user                  d1,
    decoded_if.user                  d2,
    input  logic                     in_ds_1,
    input  logic                     in_ds_2,
    input  logic                     refetch,
    output logic                     out_valid_1,
    output logic [`ISSUE_XLEN-1:0]   out_pc_1,
    output logic [`ISSUE_XLEN-1:0]   out_inst_1,
    output logic                     out_w_reg_ena_1,
    output logic [`ISSUE_REG_W-1:0]  out_w_reg_dst_1,
    output logic                     out_in_ds_1,
    output logic                     out_refetch_1,
    output logic                     out_adel_1,
    output logic                     out_tlb_refill_1,
    output logic                     out_tlb_invalid_1,
    output logic                     out_valid_2,
    output logic [`ISSUE_XLEN-1:0]   out_pc_2,
    output logic [`ISSUE_XLEN-1:0]   out_inst_2,
    output logic                     out_w_reg_ena_2,
    output logic [`ISSUE_REG_W-1:0]  out_w_reg_dst_2,
    output logic                     out_in_ds_2,
    output logic                     out_refetch_2,
    output logic                     out_adel_2,
    output logic                     out_tlb_refill_2,
    output logic                     out_tlb_invalid_2
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_1 <= 1'b0;
            out_valid_2 <= 1'b0;
        end else if (!stall) begin
            out_valid_1 <= pop_1;
            out_valid_2 <= pop_2;
        end
    end

    // payload follows valid, held under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_pc_1          <= entry_1.pc;
            out_inst_1        <= entry_1.inst;
            out_w_reg_ena_1   <= d1.w_reg_ena;
            out_w_reg_dst_1   <= d1.w_reg_dst;
            out_in_ds_1       <= in_ds_1;
            out_refetch_1     <= refetch;
            out_adel_1        <= entry_1.pc[1:0] != 2'b00;
            out_tlb_refill_1  <= entry_1.i_refill;
            out_tlb_invalid_1 <= entry_1.i_invalid;
            out_pc_2          <= entry_2.pc;
            out_inst_2        <= entry_2.inst;
            out_w_reg_ena_2   <= d2.w_reg_ena;
            out_w_reg_dst_2   <= d2.w_reg_dst;
            out_in_ds_2       <= in_ds_2;
            out_refetch_2     <= refetch;
            out_adel_2        <= entry_2.pc[1:0] != 2'b00;
            out_tlb_refill_2  <= entry_2.i_refill;
            out_tlb_invalid_2 <= entry_2.i_invalid;
        end
    end

endmodule

// File: logic/pair_issue_ctrl.sv
`include "issue_settings.svh"

module pair_issue_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   cls_refetch,
    input  logic                   ok_1,
    input  logic                   ok_2,
    decoded_if.user                d1,
    decoded_if.user                d2,
    input  logic [`ISSUE_XLEN-1:0] pc_1,
    input  logic [`ISSUE_XLEN-1:0] pc_2,
    input  logic                   i_refill_2,
    input  logic                   i_invalid_2,
    output logic                   pop_1,
    output logic                   pop_2,
    output logic                   in_ds_1,
    output logic                   in_ds_2,
    output logic                   refetch
);

    logic in_ds;
    logic jmp_1;
    logic jmp_2;
    logic raw_hazard;
    logic adel_2;
    logic pair_block;

    assign jmp_1 = d1.is_branch || d1.is_j_imme || d1.is_jr;
    assign jmp_2 = d2.is_branch || d2.is_j_imme || d2.is_jr;

    // w_reg_ena already excludes $0
    assign raw_hazard = d1.w_reg_ena &&
                        (d1.w_reg_dst == d2.rs || d1.w_reg_dst == d2.rt);

    assign adel_2 = pc_2[1:0] != 2'b00;

    assign pair_block = in_ds || raw_hazard || jmp_2 ||
                        d2.is_hilo || d2.is_cop0 || d2.is_ls || d2.is_ri ||
                        d2.is_check_ov || d2.is_mul ||
                        adel_2 || i_refill_2 || i_invalid_2 ||
                        d1.is_tlbp || d1.is_tlbr || d1.is_tlbwi;

    always_comb begin
        pop_1 = 1'b0;
        pop_2 = 1'b0;
        if (!stall && ok_1 && ok_2) begin
            pop_1 = 1'b1;
            pop_2 = !pair_block;
        end
    end

    // delay slot pending until the next slot 1 issues
    always_ff @(posedge clk) begin
        if (rst) begin
            in_ds <= 1'b0;
        end else if (pop_1) begin
            in_ds <= jmp_1 && !pop_2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            refetch <= 1'b0;
        end else if (refetch) begin
            refetch <= !cls_refetch;
        end else begin
            refetch <= (pop_1 && (d1.is_tlbr || d1.is_tlbwi)) ||
                       (pop_2 && (d2.is_tlbr || d2.is_tlbwi));
        end
    end

    assign in_ds_1 = in_ds;
    assign in_ds_2 = jmp_1 && pop_2;

endmodule

// File: logic/inst_decoder.sv
`include "issue_settings.svh"

module inst_decoder (
    input issue_pkg::inst_word_u inst,
    decoded_if.dec               dec
);

    logic                    has_dst;
    logic [`ISSUE_REG_W-1:0] dst;

    assign dec.rs        = inst.r.rs;
    assign dec.rt        = inst.i.rt;
    assign dec.w_reg_dst = has_dst ? dst : '0;
    assign dec.w_reg_ena = has_dst && (dst != '0);

    always_comb begin
        has_dst         = 1'b0;
        dst             = inst.r.rd;
        dec.is_branch   = 1'b0;
        dec.is_j_imme   = 1'b0;
        dec.is_jr       = 1'b0;
        dec.is_ls       = 1'b0;
        dec.is_mul      = 1'b0;
        dec.is_hilo     = 1'b0;
        dec.is_cop0     = 1'b0;
        dec.is_tlbp     = 1'b0;
        dec.is_tlbr     = 1'b0;
        dec.is_tlbwi    = 1'b0;
        dec.is_check_ov = 1'b0;
        dec.is_ri       = 1'b0;
        case (inst.r.opcode)
            6'h00: begin
                case (inst.r.funct)
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
                    6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
                        has_dst = 1'b1;
                    end
                    // add, sub
                    6'h20, 6'h22: begin
                        has_dst         = 1'b1;
                        dec.is_check_ov = 1'b1;
                    end
                    6'h08: dec.is_jr = 1'b1;
                    // jalr links through rd
                    6'h09: begin
                        dec.is_jr = 1'b1;
                        has_dst   = 1'b1;
                    end
                    // mfhi, mflo
                    6'h10, 6'h12: begin
                        dec.is_hilo = 1'b1;
                        has_dst     = 1'b1;
                    end
                    // mthi, mtlo, mult, multu, div, divu
                    6'h11, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b: dec.is_hilo = 1'b1;
                    default: dec.is_ri = 1'b1;
                endcase
            end
            // bltz, bgez only
            6'h01: begin
                if (inst.i.rt == 5'h00 || inst.i.rt == 5'h01) begin
                    dec.is_branch = 1'b1;
                end else begin
                    dec.is_ri = 1'b1;
                end
            end
            6'h02: dec.is_j_imme = 1'b1;
            6'h03: begin
                dec.is_j_imme = 1'b1;
                has_dst       = 1'b1;
                dst           = `ISSUE_LINK_REG;
            end
            6'h04, 6'h05, 6'h06, 6'h07: dec.is_branch = 1'b1;
            6'h08: begin
                has_dst         = 1'b1;
                dst             = inst.i.rt;
                dec.is_check_ov = 1'b1;
            end
            6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
                has_dst = 1'b1;
                dst     = inst.i.rt;
            end
            6'h10: begin
                dec.is_cop0 = 1'b1;
                case (inst.i.rs)
                    // mfc0
                    5'h00: begin
                        has_dst = 1'b1;
                        dst     = inst.i.rt;
                    end
                    5'h04: ;
                    // co bit set, tlb ops by funct
                    5'h10: begin
                        dec.is_tlbr  = inst.r.funct == 6'h01;
                        dec.is_tlbwi = inst.r.funct == 6'h02;
                        dec.is_tlbp  = inst.r.funct == 6'h08;
                        dec.is_ri    = !(dec.is_tlbr || dec.is_tlbwi || dec.is_tlbp);
                    end
                    default: dec.is_ri = 1'b1;
                endcase
            end
            // special2 mul
            6'h1c: begin
                if (inst.r.funct == 6'h02) begin
                    dec.is_mul = 1'b1;
                    has_dst    = 1'b1;
                end else begin
                    dec.is_ri = 1'b1;
                end
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
                dec.is_ls = 1'b1;
                has_dst   = 1'b1;
                dst       = inst.i.rt;
            end
            6'h28, 6'h29, 6'h2b: dec.is_ls = 1'b1;
            default: dec.is_ri = 1'b1;
        endcase
    end

endmodule

// File: logic/decoded_if.sv
`include "issue_settings.svh"

interface decoded_if;

    logic [`ISSUE_REG_W-1:0] rs;
    logic [`ISSUE_REG_W-1:0] rt;
    logic [`ISSUE_REG_W-1:0] w_reg_dst;
    logic                    w_reg_ena;

    // instruction classes
    logic is_branch;
    logic is_j_imme;
    logic is_jr;
    logic is_ls;
    logic is_mul;
    logic is_hilo;
    logic is_cop0;
    logic is_tlbp;
    logic is_tlbr;
    logic is_tlbwi;
    logic is_check_ov;
    logic is_ri;

    modport dec (
        output rs, rt, w_reg_dst, w_reg_ena,
        output is_branch, is_j_imme, is_jr, is_ls, is_mul, is_hilo,
        output is_cop0, is_tlbp, is_tlbr, is_tlbwi, is_check_ov, is_ri
    );

    modport user (
        input rs, rt, w_reg_dst, w_reg_ena,
        input is_branch, is_j_imme, is_jr, is_ls, is_mul, is_hilo,
        input is_cop0, is_tlbp, is_tlbr, is_tlbwi, is_check_ov, is_ri
    );

endinterface

// File: logic/issue_pkg.sv
`include "issue_settings.svh"

package issue_pkg;

    // one fetch queue entry, msb first
    typedef struct packed {
        logic                    pred_taken;
        logic [`ISSUE_XLEN-1:0] pred_target;
        logic                    i_refill;
        logic                    i_invalid;
        logic [`ISSUE_XLEN-1:0] pc;
        logic [`ISSUE_XLEN-1:0] inst;
    } fetch_entry_t;

    // register form
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`ISSUE_REG_W-1:0] rs;
        logic [`ISSUE_REG_W-1:0] rt;
        logic [`ISSUE_REG_W-1:0] rd;
        logic [4:0]              sa;
        logic [5:0]              funct;
    } inst_r_t;

    // immediate form
    // jump target is {rs, rt, imm}
    typedef struct packed {
        logic [5:0]              opcode;
        logic [`ISSUE_REG_W-1:0] rs;
        logic [`ISSUE_REG_W-1:0] rt;
        logic [15:0]             imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

endpackage

// File: logic/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// data and address width
`define ISSUE_XLEN 32

// pred_taken + pred_target + two fetch fault bits + pc + inst
`define ISSUE_ENTRY_W 99

`define ISSUE_REG_W 5

// jal writes the return address here
`define ISSUE_LINK_REG 5'd31

`endif
